/* src/bp_pkg.sv */
/*
 * Shared constants of the branch prediction unit.
 * Counter width and APB register map, used as bp_pkg::name.
 */
package bp_pkg;

	// Width of each event counter, wraps around
	localparam int STAT_WIDTH = 16;

	// APB register offsets
	localparam logic [31:0] REG_PREDICTIONS = 32'h0;	// Accepted predictions, read only
	localparam logic [31:0] REG_MISPREDICTS = 32'h4;	// Mispredicts, read only
	localparam logic [31:0] REG_CTRL        = 32'h8;	// Control, write only, reads as 0

	// Control register bits
	localparam int CTRL_CLEAR_BIT = 0;	// Clears PHT, GHR and checkpoint queue
	localparam int CTRL_ZERO_BIT  = 1;	// Zeroes both event counters

endpackage

/* src/bp_update_if.sv */
/*
 * Update path from the control block to the predictor table.
 * No handshake, every signal acts at the next rising edge.
 */
`timescale 1ns/1ns

interface bp_update_if #(
	parameter int GHR_BITS = 4
);
	logic                upd_valid;	// Write upd_taken into the PHT
	logic [GHR_BITS-1:0] upd_index;
	logic                upd_taken;
	logic                restore_valid;	// Roll the GHR back
	logic [GHR_BITS-1:0] restore_ghr;
	logic                clear;	// Clear PHT and GHR

	// Control side drives everything
	modport ctrl (output upd_valid, upd_index, upd_taken, restore_valid, restore_ghr, clear);

	// Table side only listens
	modport tbl (input upd_valid, upd_index, upd_taken, restore_valid, restore_ghr, clear);

endinterface

/* src/gshare_pht.sv */
/*
 * Gshare predictor core: GHR, one-bit PHT and the index hash.
 * Prediction is registered one cycle after accept; repairs arrive on the update interface.
 */
`timescale 1ns/1ns

module gshare_pht #(
	parameter int GHR_BITS = 4
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                accept,	// Branch taken in this cycle
	input  logic [31:0]         pc,
	output logic [GHR_BITS-1:0] pred_index,	// Checkpoint fields, combinational
	output logic [GHR_BITS-1:0] pred_ghr,
	output logic                pred_bit,
	output logic                pred_valid,	// Registered response
	output logic                pred_taken,
	bp_update_if.tbl            upd
);

	localparam int PHT_SIZE = 2 ** GHR_BITS;

	logic [GHR_BITS-1:0] ghr;
	logic [PHT_SIZE-1:0] pht;	// One bit per entry, 1 is taken

	// Hash skips the byte offset of the PC
	assign pred_index = ghr ^ pc[GHR_BITS+1:2];
	assign pred_ghr   = ghr;	// History before this branch
	assign pred_bit   = pht[pred_index];

	always_ff @(posedge clock) begin
		if (reset) begin
			pht        <= '0;	// All not taken
			ghr        <= '0;
			pred_valid <= 1'b0;
			pred_taken <= 1'b0;
		end else begin
			pred_valid <= accept;	// Exactly one cycle after accept
			if (accept)
				pred_taken <= pred_bit;

			// Clear first, then repair, then speculative shift
			if (upd.clear) begin
				pht <= '0;
				ghr <= '0;
			end else if (upd.upd_valid || upd.restore_valid) begin
				if (upd.upd_valid)
					pht[upd.upd_index] <= upd.upd_taken;	// Train with the real outcome
				if (upd.restore_valid)
					ghr <= upd.restore_ghr;
			end else if (accept) begin
				ghr <= {ghr[GHR_BITS-2:0], pred_bit};	// Speculative history
			end
		end
	end

endmodule

/* src/checkpoint_queue.sv */
/*
 * In-order FIFO of prediction checkpoints (PHT index, GHR, predicted bit).
 * Head entry is the oldest unresolved branch; flush empties it in one cycle.
 */
`timescale 1ns/1ns

module checkpoint_queue #(
	parameter int GHR_BITS    = 4,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                push,
	input  logic [GHR_BITS-1:0] push_index,
	input  logic [GHR_BITS-1:0] push_ghr,
	input  logic                push_pred,
	input  logic                pop,
	input  logic                flush,	// Drops every entry
	output logic [GHR_BITS-1:0] head_index,
	output logic [GHR_BITS-1:0] head_ghr,
	output logic                head_pred,
	output logic                empty,
	output logic                full
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	// Entry storage
	logic [GHR_BITS-1:0] index_mem [QUEUE_DEPTH];
	logic [GHR_BITS-1:0] ghr_mem   [QUEUE_DEPTH];
	logic                pred_mem  [QUEUE_DEPTH];

	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;

	logic do_push;
	logic do_pop;

	assign empty   = (count == '0);
	assign full    = (count == CNT_W'(QUEUE_DEPTH));
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign head_index = index_mem[rd_ptr];
	assign head_ghr   = ghr_mem[rd_ptr];
	assign head_pred  = pred_mem[rd_ptr];

	// Pointer wrap also works for depths that are not a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		next_ptr = (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_ff @(posedge clock) begin
		if (do_push && !flush) begin
			index_mem[wr_ptr] <= push_index;
			ghr_mem[wr_ptr]   <= push_ghr;
			pred_mem[wr_ptr]  <= push_pred;
		end
	end

	always_ff @(posedge clock) begin
		if (reset || flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
		end
	end

endmodule

/* src/bp_stats_apb.sv */
/*
 * APB slave with the prediction and mispredict counters and the control register.
 * No wait states; unmapped offsets answer with pslverr.
 */
`timescale 1ns/1ns

module bp_stats_apb (
	input  logic        clock,
	input  logic        reset,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] paddr,
	input  logic [31:0] pwdata,
	input  logic        count_pred,	// One accepted prediction
	input  logic        count_mispredict,	// One mispredicted resolve
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr,
	output logic        clear_req	// Pulse during the access cycle
);

	logic [bp_pkg::STAT_WIDTH-1:0] pred_count;
	logic [bp_pkg::STAT_WIDTH-1:0] mispredict_count;

	logic access;
	logic mapped;
	logic ctrl_write;

	assign access = psel && penable;
	assign mapped = (paddr == bp_pkg::REG_PREDICTIONS) ||
		(paddr == bp_pkg::REG_MISPREDICTS) ||
		(paddr == bp_pkg::REG_CTRL);
	assign ctrl_write = access && pwrite && (paddr == bp_pkg::REG_CTRL);

	assign pready    = 1'b1;	// Never stalls
	assign pslverr   = access && !mapped;
	assign clear_req = ctrl_write && pwdata[bp_pkg::CTRL_CLEAR_BIT];

	// Read mux, control register reads as zero
	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			if (paddr == bp_pkg::REG_PREDICTIONS)
				prdata = {{(32 - bp_pkg::STAT_WIDTH){1'b0}}, pred_count};
			else if (paddr == bp_pkg::REG_MISPREDICTS)
				prdata = {{(32 - bp_pkg::STAT_WIDTH){1'b0}}, mispredict_count};
		end
	end

	// Event counters wrap around; a zero request beats an increment
	always_ff @(posedge clock) begin
		if (reset || (ctrl_write && pwdata[bp_pkg::CTRL_ZERO_BIT])) begin
			pred_count       <= '0;
			mispredict_count <= '0;
		end else begin
			pred_count       <= pred_count + bp_pkg::STAT_WIDTH'(count_pred);
			mispredict_count <= mispredict_count + bp_pkg::STAT_WIDTH'(count_mispredict);
		end
	end

endmodule

/* src/bp_ctrl.sv */
/*
 * Control of the predictor: accepts branches, resolves the oldest checkpoint,
 * and drives queue pushes, pops, flushes, PHT training and GHR rollback.
 */
`timescale 1ns/1ns

module bp_ctrl #(
	parameter int GHR_BITS    = 4,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                branch_valid,
	input  logic                resolve_valid,	// Refers to the oldest branch
	input  logic                resolve_taken,
	input  logic                q_full,
	input  logic                q_empty,
	input  logic [GHR_BITS-1:0] head_index,
	input  logic [GHR_BITS-1:0] head_ghr,
	input  logic                head_pred,
	input  logic [GHR_BITS-1:0] pred_index,
	input  logic [GHR_BITS-1:0] pred_ghr,
	input  logic                pred_bit,
	input  logic                clear_req,
	output logic                pred_ready,
	output logic                push,	// Also the accept strobe of the table
	output logic [GHR_BITS-1:0] push_index,
	output logic [GHR_BITS-1:0] push_ghr,
	output logic                push_pred,
	output logic                pop,
	output logic                flush,
	output logic                count_pred,
	output logic                count_mispredict,
	bp_update_if.ctrl           upd
);

	logic running;	// Low through reset, holds pred_ready off
	logic resolving;
	logic mispredict;

	// Hash needs at least two history bits, queue at least one slot
	if (GHR_BITS < 2 || QUEUE_DEPTH < 1)
		$error("bp_ctrl: GHR_BITS must be 2 or more and QUEUE_DEPTH 1 or more");

	always_ff @(posedge clock) begin
		if (reset)
			running <= 1'b0;
		else
			running <= 1'b1;
	end

	// Resolution and clear take the cycle, so the request is dropped
	assign pred_ready = running && !q_full && !resolve_valid && !clear_req;
	assign push       = branch_valid && pred_ready;
	assign push_index = pred_index;
	assign push_ghr   = pred_ghr;	// History before the shift
	assign push_pred  = pred_bit;

	assign resolving  = resolve_valid && !q_empty;	// Nothing to resolve when empty
	assign mispredict = resolving && (resolve_taken != head_pred);

	assign pop   = resolving && !mispredict;
	assign flush = mispredict || clear_req;	// Younger entries are wrong path

	// Repair: train the entry and rebuild history with the real outcome
	assign upd.upd_valid     = mispredict;
	assign upd.upd_index     = head_index;
	assign upd.upd_taken     = resolve_taken;
	assign upd.restore_valid = mispredict;
	assign upd.restore_ghr   = {head_ghr[GHR_BITS-2:0], resolve_taken};
	assign upd.clear         = clear_req;

	assign count_pred       = push;
	assign count_mispredict = mispredict;

endmodule

/* src/bpu_top.sv */
/*
 * Top level of the gshare branch prediction unit.
 * Prediction, resolution and APB register ports; instances and wires only.
 */
`timescale 1ns/1ns

module bpu_top #(
	parameter int GHR_BITS    = 4,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic        clock,
	input  logic        reset,
	// Prediction request and response
	input  logic        branch_valid,
	input  logic [31:0] pc,
	output logic        pred_ready,
	output logic        pred_valid,
	output logic        pred_taken,
	// Resolution of the oldest branch
	input  logic        resolve_valid,
	input  logic        resolve_taken,
	// APB register port
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);

	logic                push;
	logic                pop;
	logic                flush;
	logic                q_full;
	logic                q_empty;
	logic                clear_req;
	logic                count_pred;
	logic                count_mispredict;
	logic [GHR_BITS-1:0] pred_index;
	logic [GHR_BITS-1:0] pred_ghr;
	logic                pred_bit;
	logic [GHR_BITS-1:0] push_index;
	logic [GHR_BITS-1:0] push_ghr;
	logic                push_pred;
	logic [GHR_BITS-1:0] head_index;
	logic [GHR_BITS-1:0] head_ghr;
	logic                head_pred;

	bp_update_if #(.GHR_BITS(GHR_BITS)) u_update ();

	bp_ctrl #(.GHR_BITS(GHR_BITS), .QUEUE_DEPTH(QUEUE_DEPTH)) u_ctrl (
		.clock, .reset, .branch_valid, .resolve_valid, .resolve_taken,
		.q_full, .q_empty, .head_index, .head_ghr, .head_pred,
		.pred_index, .pred_ghr, .pred_bit, .clear_req,
		.pred_ready, .push, .push_index, .push_ghr, .push_pred,
		.pop, .flush, .count_pred, .count_mispredict,
		.upd(u_update.ctrl)
	);

	gshare_pht #(.GHR_BITS(GHR_BITS)) u_pht (
		.clock, .reset, .accept(push), .pc,
		.pred_index, .pred_ghr, .pred_bit, .pred_valid, .pred_taken,
		.upd(u_update.tbl)
	);

	checkpoint_queue #(.GHR_BITS(GHR_BITS), .QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
		.clock, .reset, .push, .push_index, .push_ghr, .push_pred, .pop, .flush,
		.head_index, .head_ghr, .head_pred, .empty(q_empty), .full(q_full)
	);

	bp_stats_apb u_stats (
		.clock, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
		.count_pred, .count_mispredict, .prdata, .pready, .pslverr, .clear_req
	);

endmodule

/* tb/bpu_asserts.sv */
/*
 * Concurrent checks of the prediction handshake, bound into bpu_top.
 */
`timescale 1ns/1ns

module bpu_asserts (
	input logic clock,
	input logic reset,
	input logic push,	// Accept strobe inside the top level
	input logic pred_valid,
	input logic pred_ready,
	input logic resolve_valid,
	input logic q_full,
	input logic clear_req
);

	int error_count = 0;	// Failed assertions so far

	response_after_accept: assert property (@(posedge clock) disable iff (reset)
		pred_valid |-> $past(push))
	else begin
		error_count++;
		$error("pred_valid high without an accept one cycle earlier");
	end

	// Resolution owns the cycle
	ready_low_on_resolve: assert property (@(posedge clock) disable iff (reset)
		resolve_valid |-> !pred_ready)
	else begin
		error_count++;
		$error("pred_ready high while resolve_valid is high");
	end

	ready_low_when_full: assert property (@(posedge clock) disable iff (reset)
		q_full |-> !pred_ready)
	else begin
		error_count++;
		$error("pred_ready high with a full checkpoint queue");
	end

	no_push_on_clear: assert property (@(posedge clock) disable iff (reset)
		clear_req |-> !push)
	else begin
		error_count++;
		$error("Checkpoint pushed while a clear is applied");
	end

endmodule

/* tb/bpu_tb.sv */
/*
 * Testbench of the gshare branch prediction unit.
 * Runs a step table against a behavioral model, then random predicts and resolves.
 */
`timescale 1ns/1ns

module bpu_tb;

	localparam int GHR_BITS    = 4;
	localparam int QUEUE_DEPTH = 4;
	localparam int TIMEOUT     = 50;	// Cycles allowed for any single wait
	localparam int NUM_STEPS   = 26;
	localparam int NUM_RANDOM  = 80;

	localparam logic [2:0] OP_PREDICT = 3'd0;	// arg is the PC
	localparam logic [2:0] OP_RESOLVE = 3'd1;	// arg bit 0 is the outcome
	localparam logic [2:0] OP_WRITE   = 3'd2;
	localparam logic [2:0] OP_READ    = 3'd3;
	localparam logic [2:0] OP_HELD    = 3'd4;	// Request held on a full queue with data as the outcome

	typedef struct packed {
		logic [2:0]  op;
		logic [31:0] arg;	// PC, outcome or APB address
		logic [31:0] data;	// APB write data or held-request outcome
		logic        has_value;	// Step fixes an expected value
		logic [31:0] value;
	} step_t;

	logic        clock;
	logic        reset;
	logic        branch_valid;
	logic [31:0] pc;
	logic        pred_ready;
	logic        pred_valid;
	logic        pred_taken;
	logic        resolve_valid;
	logic        resolve_taken;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	// Reference model state
	logic [GHR_BITS-1:0]    model_ghr;
	logic [2**GHR_BITS-1:0] model_pht;
	logic [2*GHR_BITS:0]    model_queue [$];	// {index, GHR before, predicted bit}
	int                     model_preds;
	int                     model_mispredicts;

	step_t steps [NUM_STEPS];

	bpu_top #(.GHR_BITS(GHR_BITS), .QUEUE_DEPTH(QUEUE_DEPTH)) u_bpu_top (.*);

	bind bpu_top bpu_asserts u_asserts (
		.clock, .reset, .push, .pred_valid, .pred_ready, .resolve_valid, .q_full, .clear_req
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Test failures found");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected)
			fail_run($sformatf("CHECK FAILED at %0t ns: %s = 0x%0h, expected 0x%0h",
				$time, name, actual, expected));
	endtask

	// Polls pred_ready or pready at falling edges
	task automatic wait_for(input bit on_apb, input string name);
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (!(on_apb ? pready : pred_ready)) begin
			cycles++;
			if (cycles > TIMEOUT)
				fail_run({"Timeout while waiting for ", name});
			@(negedge clock);
		end
	endtask

	// History XOR PC bits picks the entry and the guess shifts into history
	task automatic model_predict(input logic [31:0] addr, output logic bit_out);
		logic [GHR_BITS-1:0] index;
		index = model_ghr ^ addr[GHR_BITS+1:2];
		bit_out = model_pht[index];
		model_queue.push_back({index, model_ghr, bit_out});
		model_ghr = {model_ghr[GHR_BITS-2:0], bit_out};
		model_preds++;
	endtask

	task automatic model_resolve(input logic outcome);
		logic [2*GHR_BITS:0] head;
		if (model_queue.size() == 0)
			return;	// Resolve on an empty queue is ignored
		head = model_queue.pop_front();
		if (head[0] != outcome) begin
			model_mispredicts++;
			model_pht[head[2*GHR_BITS:GHR_BITS+1]] = outcome;	// Train with the real outcome
			model_ghr = {head[GHR_BITS-1:1], outcome};	// Checkpoint plus outcome
			model_queue.delete();	// Younger branches were wrong path
		end
	endtask

	// One resolve cycle that drops any request made alongside it
	task automatic resolve_once(input logic outcome);
		@(posedge clock);
		#1;
		resolve_valid = 1'b1;
		resolve_taken = outcome;
		@(negedge clock);
		check_value("pred_ready during resolve", 32'(pred_ready), 0);
		model_resolve(outcome);
		@(posedge clock);
		#1;
		resolve_valid = 1'b0;
		check_value("pred_valid after resolve cycle", 32'(pred_valid), 0);
	endtask

	task automatic apply_step(input step_t s);
		logic        predicted;
		logic        unmapped;
		logic [31:0] expected;
		case (s.op)
			OP_PREDICT, OP_HELD: begin
				@(posedge clock);
				#1;
				branch_valid = 1'b1;
				pc = s.arg;
				if (s.op == OP_HELD) begin
					@(negedge clock);
					check_value("pred_ready on full queue", 32'(pred_ready), 0);
					resolve_once(s.data[0]);	// Request stays up through the resolve
				end
				wait_for(1'b0, "pred_ready");
				model_predict(s.arg, predicted);
				@(posedge clock);
				#1;
				branch_valid = 1'b0;
				@(negedge clock);
				check_value("pred_valid", 32'(pred_valid), 1);
				check_value("pred_taken", 32'(pred_taken), 32'(predicted));
				if (s.has_value)
					check_value("pred_taken from table", 32'(pred_taken), s.value);
			end
			OP_RESOLVE: resolve_once(s.arg[0]);
			OP_WRITE, OP_READ: begin
				unmapped = !(s.arg inside {bp_pkg::REG_PREDICTIONS, bp_pkg::REG_MISPREDICTS,
					bp_pkg::REG_CTRL});
				@(posedge clock);
				#1;
				psel = 1'b1;	// Setup phase
				pwrite = (s.op == OP_WRITE);
				paddr = s.arg;
				pwdata = s.data;
				@(posedge clock);
				#1;
				penable = 1'b1;
				wait_for(1'b1, "pready");
				check_value("pslverr", 32'(pslverr), 32'(unmapped));
				if (s.op == OP_READ) begin
					if (s.arg == bp_pkg::REG_PREDICTIONS)
						expected = model_preds & 32'hffff;	// Counters wrap at 16 bits
					else if (s.arg == bp_pkg::REG_MISPREDICTS)
						expected = model_mispredicts & 32'hffff;
					else
						expected = '0;
					check_value("prdata", prdata, expected);
					if (s.has_value)
						check_value("prdata from table", prdata, s.value);
				end else if (s.arg == bp_pkg::REG_CTRL) begin
					if (s.data[0]) begin
						model_pht = '0;
						model_ghr = '0;
						model_queue.delete();
					end
					if (s.data[1]) begin
						model_preds = 0;
						model_mispredicts = 0;
					end
				end
				@(posedge clock);
				#1;
				psel = 1'b0;
				penable = 1'b0;
			end
			default: fail_run("Unknown operation in the step table");
		endcase
	endtask

	initial begin
		step_t step;
		void'($urandom(32'hc457));
		reset = 1'b1;
		branch_valid = 1'b0;
		pc = '0;
		resolve_valid = 1'b0;
		resolve_taken = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		model_ghr = '0;
		model_pht = '0;
		model_preds = 0;
		model_mispredicts = 0;

		steps = '{
			'{OP_PREDICT, 32'h100, 32'h0, 1'b1, 32'h0},	// Fresh PHT predicts not taken
			'{OP_PREDICT, 32'h104, 32'h0, 1'b1, 32'h0},
			'{OP_RESOLVE, 32'h0,   32'h0, 1'b0, 32'h0},
			'{OP_RESOLVE, 32'h0,   32'h0, 1'b0, 32'h0},
			'{OP_PREDICT, 32'h108, 32'h0, 1'b1, 32'h0},
			'{OP_RESOLVE, 32'h1,   32'h0, 1'b0, 32'h0},	// Mispredict trains entry 2
			'{OP_PREDICT, 32'h13c, 32'h0, 1'b1, 32'h0},	// Four zeros walk the GHR back to 0
			'{OP_PREDICT, 32'h13c, 32'h0, 1'b1, 32'h0},
			'{OP_PREDICT, 32'h13c, 32'h0, 1'b1, 32'h0},
			'{OP_PREDICT, 32'h13c, 32'h0, 1'b1, 32'h0},	// Queue now full
			'{OP_HELD,    32'h108, 32'h0, 1'b1, 32'h1},	// Retrained PC predicts taken
			'{OP_RESOLVE, 32'h1,   32'h0, 1'b0, 32'h0},	// Mispredict flushes younger branches
			'{OP_PREDICT, 32'h120, 32'h0, 1'b1, 32'h1},	// Uses the restored GHR
			'{OP_RESOLVE, 32'h0,   32'h0, 1'b0, 32'h0},	// Applies to the new branch
			'{OP_PREDICT, 32'h120, 32'h0, 1'b1, 32'h1},
			'{OP_RESOLVE, 32'h1,   32'h0, 1'b0, 32'h0},
			'{OP_READ,    bp_pkg::REG_PREDICTIONS, 32'h0, 1'b1, 32'd10},
			'{OP_READ,    bp_pkg::REG_MISPREDICTS, 32'h0, 1'b1, 32'd3},
			'{OP_READ,    bp_pkg::REG_CTRL,        32'h0, 1'b1, 32'h0},
			'{OP_READ,    32'h10,  32'h0, 1'b1, 32'h0},	// Unmapped
			'{OP_WRITE,   32'h20,  32'h1, 1'b0, 32'h0},	// Unmapped write has no effect
			'{OP_WRITE,   bp_pkg::REG_CTRL,        32'h3, 1'b0, 32'h0},	// Clear and zero
			'{OP_READ,    bp_pkg::REG_PREDICTIONS, 32'h0, 1'b1, 32'h0},
			'{OP_READ,    bp_pkg::REG_MISPREDICTS, 32'h0, 1'b1, 32'h0},
			'{OP_PREDICT, 32'h108, 32'h0, 1'b1, 32'h0},	// Entry 2 cleared
			'{OP_RESOLVE, 32'h0,   32'h0, 1'b0, 32'h0}
		};

		repeat (9) @(posedge clock);
		@(negedge clock);
		check_value("pred_ready in reset", 32'(pred_ready), 0);
		check_value("pred_valid in reset", 32'(pred_valid), 0);
		@(posedge clock);
		#1;
		reset = 1'b0;

		for (int i = 0; i < NUM_STEPS; i++)
			apply_step(steps[i]);

		// Random mix that predicts only while the model queue has room
		for (int i = 0; i < NUM_RANDOM; i++) begin
			step = '0;
			if (model_queue.size() < QUEUE_DEPTH && $urandom_range(1, 0) == 1) begin
				step.op = OP_PREDICT;
				step.arg = $urandom;
			end else begin
				step.op = OP_RESOLVE;
				step.arg = 32'($urandom_range(1, 0));
			end
			apply_step(step);
		end
		step = '0;
		step.op = OP_READ;
		step.arg = bp_pkg::REG_PREDICTIONS;
		apply_step(step);
		step.arg = bp_pkg::REG_MISPREDICTS;
		apply_step(step);

		if (u_bpu_top.u_asserts.error_count == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			$display("%0d concurrent assertion failures", u_bpu_top.u_asserts.error_count);
			$display("Test failures found");
			$fatal(1, "Assertion failures during the run");
		end
	end

endmodule

/* bpu.f */
src/bp_pkg.sv
src/bp_update_if.sv
src/gshare_pht.sv
src/checkpoint_queue.sv
src/bp_stats_apb.sv
src/bp_ctrl.sv
src/bpu_top.sv
tb/bpu_asserts.sv
tb/bpu_tb.sv

/* Makefile */
# Verilator build and run of the branch prediction unit testbench

SIM = obj_dir/bpu_sim

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module bpu_tb -f bpu.f -o bpu_sim

# Error limit raised so assertion failures reach the testbench summary
# The pass message in the output decides the exit status
run: compile
	./$(SIM) +verilator+error+limit+100 | \
		awk '{ print } /All tests passed!/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
